// ==== hw/branch_predecode.sv ====
`include "fetch_defs.svh"

module branch_predecode (
    input  fetch_pkg::inst_t i_inst,
    input  logic             i_compressed,
    output logic             o_branch
);
    import fetch_pkg::*;

    // 32-bit fields
    logic [6:0] opcode;

    // compressed fields
    logic [1:0] c_quad;
    logic [2:0] c_funct3;
    logic [4:0] c_rs1;
    logic [4:0] c_rs2;

    logic full_branch;
    logic c_q1_branch;
    logic c_q2_branch;
    inst_t      inst;

    assign inst     = i_inst;
    assign opcode   = inst[6:0];
    assign c_quad   = inst[1:0];
    assign c_funct3 = inst[15:13];
    assign c_rs1    = inst[11:7];
    assign c_rs2    = inst[6:2];

    // jal, jalr and conditional branches
    assign full_branch = (opcode == `OP_JAL) || (opcode == `OP_JALR) ||
                         (opcode == `OP_BRANCH);

    // quadrant 1: c.j (101), c.beqz (110), c.bnez (111)
    // funct3 001 is c.addiw on rv64, not c.jal
    always_comb begin
        c_q1_branch = 1'b0;
        if (c_quad == `C_Q1) begin
            case (c_funct3)
                3'b101,
                3'b110,
                3'b111:  c_q1_branch = 1'b1;
                default: c_q1_branch = 1'b0;
            endcase
        end
    end

    // quadrant 2: c.jr and c.jalr share funct3 100 with rs2 zero
    // rs1 zero there is c.ebreak or reserved
    assign c_q2_branch = (c_quad == `C_Q2) && (c_funct3 == 3'b100) &&
                         (c_rs2 == 5'd0) && (c_rs1 != 5'd0);

    // pick the form the slot was decoded as
    assign o_branch = i_compressed ? (c_q1_branch || c_q2_branch) : full_branch;

endmodule

// ==== hw/fetch_ctrl.sv ====
`include "fetch_defs.svh"

module fetch_ctrl (
    input  logic i_clk,
    input  logic i_rst_n,
    input  logic i_mem_valid,
    input  logic i_sent,
    input  logic i_branched,
    input  logic i_branch_valid,
    output logic o_mem_ren,
    output logic o_in_resol,
    output logic o_hold
);
    import fetch_pkg::*;

    fetch_state_e state;
    fetch_state_e next_state;

    // where a send leads, a branch in either slot stops fetch for resolution
    fetch_state_e after_send;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= ST_INIT;
        end else begin
            state <= next_state;
        end
    end

    assign after_send = i_branched ? ST_RESOL : ST_FETCH;

    always_comb begin
        next_state = state;
        case (state)
            // first cycle out of reset, kick off the reset address read
            ST_INIT: begin
                next_state = ST_FETCH;
            end
            // read issued last cycle, data may already be here
            ST_FETCH: begin
                if (i_sent) begin
                    next_state = after_send;
                end else if (i_mem_valid) begin
                    next_state = ST_VALID;
                end else begin
                    next_state = ST_CACHE;
                end
            end
            // memory slower than one cycle, pc and request held
            ST_CACHE: begin
                if (i_mem_valid) begin
                    if (i_sent) begin
                        next_state = after_send;
                    end else begin
                        next_state = ST_VALID;
                    end
                end
            end
            // decode stalled, output comes from the hold registers
            ST_VALID: begin
                if (i_sent) begin
                    next_state = after_send;
                end
            end
            // no reads until the branch target arrives
            ST_RESOL: begin
                if (i_branch_valid) begin
                    next_state = ST_FETCH;
                end
            end
            default: begin
                next_state = ST_INIT;
            end
        endcase
    end

    // single-cycle request on every entry into FETCH
    // next state is FETCH during reset too, so keep the request off there
    assign o_mem_ren = i_rst_n && (next_state == ST_FETCH);

    assign o_in_resol = (state == ST_RESOL);
    assign o_hold     = (state == ST_VALID);

endmodule

// ==== hw/fetch_hold.sv ====
`include "fetch_defs.svh"

module fetch_hold (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_mem_valid,
    input  logic                   i_hold,
    input  fetch_pkg::inst_t       i_inst0,
    input  fetch_pkg::inst_t       i_inst1,
    input  fetch_pkg::slot_flags_t i_compressed,
    input  logic                   i_count,
    output logic                   o_output_valid,
    output fetch_pkg::inst_t       o_inst0,
    output fetch_pkg::inst_t       o_inst1,
    output fetch_pkg::slot_flags_t o_compressed,
    output logic                   o_count
);
    import fetch_pkg::*;

    inst_t       hold_inst0;
    inst_t       hold_inst1;
    slot_flags_t hold_compressed;
    logic        hold_count;

    // copy of the word being presented, in case decode is not ready
    // memory only answers in FETCH or CACHE, never while holding
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hold_inst0      <= '0;
            hold_inst1      <= '0;
            hold_compressed <= '0;
            hold_count      <= 1'b0;
        end else if (i_mem_valid) begin
            hold_inst0      <= i_inst0;
            hold_inst1      <= i_inst1;
            hold_compressed <= i_compressed;
            hold_count      <= i_count;
        end
    end

    // live data in the answer cycle, held copy afterwards
    always_comb begin
        if (i_hold) begin
            o_inst0      = hold_inst0;
            o_inst1      = hold_inst1;
            o_compressed = hold_compressed;
            o_count      = hold_count;
        end else begin
            o_inst0      = i_inst0;
            o_inst1      = i_inst1;
            o_compressed = i_compressed;
            o_count      = i_count;
        end
    end

    assign o_output_valid = i_mem_valid || i_hold;

endmodule

// ==== hw/fetch_pc.sv ====
`include "fetch_defs.svh"

module fetch_pc (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_sent,
    input  logic                   i_in_resol,
    input  logic                   i_branch_valid,
    input  fetch_pkg::vaddr_t      i_branch_target,
    input  logic                   i_branch0,
    input  fetch_pkg::slot_flags_t i_compressed,
    output fetch_pkg::vaddr_t      o_pc
);
    import fetch_pkg::*;

    vaddr_t     pc;
    vaddr_t     next_pc;
    logic [3:0] advance;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc <= `FETCH_RESET_ADDR;
        end else begin
            pc <= next_pc;
        end
    end

    // bytes consumed by one send
    // branch in slot 0 drops slot 1, so only slot 0 length counts
    always_comb begin
        advance = 4'd8;
        casez ({i_branch0, i_compressed})
            3'b000: advance = 4'd8;
            3'b001,
            3'b010: advance = 4'd6;
            3'b011: advance = 4'd4;
            3'b1?0: advance = 4'd4;
            3'b1?1: advance = 4'd2;
            default: advance = 4'd8;
        endcase
    end

    // resolved target wins in RESOL
    // elsewhere advance on a send and hold otherwise
    always_comb begin
        next_pc = pc;
        if (i_in_resol) begin
            if (i_branch_valid) begin
                next_pc = i_branch_target;
            end
        end else if (i_sent) begin
            next_pc = pc + vaddr_t'(advance);
        end
    end

    // read address is the registered pc, stable for the whole request
    assign o_pc = pc;

endmodule

// ==== hw/fetch_pkg.sv ====
`include "fetch_defs.svh"

package fetch_pkg;

    // pc, memory read address and branch target
    typedef logic [`FETCH_VADDR_W-1:0] vaddr_t;

    // raw word returned by instruction memory
    typedef logic [`FETCH_WORD_W-1:0] fetch_word_t;

    // one instruction slot, only the low half is meaningful when compressed
    typedef logic [`INST_W-1:0] inst_t;

    // one bit per slot, bit 0 is slot 0
    typedef logic [1:0] slot_flags_t;

    // fetch FSM states
    typedef enum logic [2:0] {
        ST_FETCH = 3'h0,
        ST_CACHE = 3'h1,
        ST_VALID = 3'h2,
        ST_RESOL = 3'h3,
        ST_INIT  = 3'h4
    } fetch_state_e;

endpackage

// ==== hw/fetch_unit.sv ====
`include "fetch_defs.svh"

module fetch_unit (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    // instruction memory, one outstanding read
    output logic                   o_mem_ren,
    output fetch_pkg::vaddr_t      o_mem_raddr,
    input  fetch_pkg::fetch_word_t i_mem_rdata,
    input  logic                   i_mem_valid,
    // resolved target after a control-flow send
    input  fetch_pkg::vaddr_t      i_branch_target,
    input  logic                   i_branch_valid,
    // decode side
    input  logic                   i_output_ready,
    output logic                   o_output_valid,
    output fetch_pkg::inst_t       o_inst0,
    output fetch_pkg::inst_t       o_inst1,
    output fetch_pkg::slot_flags_t o_compressed,
    output logic                   o_count
);
    import fetch_pkg::*;

    inst_t       pick_inst0;
    inst_t       pick_inst1;
    slot_flags_t pick_compressed;
    slot_flags_t branch;
    logic        count;
    logic        sent;
    logic        branched;
    logic        in_resol;
    logic        hold;

    // slice the memory word into two slots
    inst_pick u_pick (
        .i_word       (i_mem_rdata),
        .o_inst0      (pick_inst0),
        .o_inst1      (pick_inst1),
        .o_compressed (pick_compressed)
    );

    // presented copy, live on the answer cycle or held under back-pressure
    fetch_hold u_hold (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_mem_valid    (i_mem_valid),
        .i_hold         (hold),
        .i_inst0        (pick_inst0),
        .i_inst1        (pick_inst1),
        .i_compressed   (pick_compressed),
        .i_count        (count),
        .o_output_valid (o_output_valid),
        .o_inst0        (o_inst0),
        .o_inst1        (o_inst1),
        .o_compressed   (o_compressed),
        .o_count        (o_count)
    );

    // predecode what decode actually sees
    // memory data may have moved on while holding
    branch_predecode u_predecode0 (
        .i_inst       (o_inst0),
        .i_compressed (o_compressed[0]),
        .o_branch     (branch[0])
    );

    branch_predecode u_predecode1 (
        .i_inst       (o_inst1),
        .i_compressed (o_compressed[1]),
        .o_branch     (branch[1])
    );

    // no speculation past a control-flow instruction in slot 0
    assign count    = !branch[0];
    assign sent     = o_output_valid && i_output_ready;
    assign branched = |branch;

    fetch_ctrl u_ctrl (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_mem_valid    (i_mem_valid),
        .i_sent         (sent),
        .i_branched     (branched),
        .i_branch_valid (i_branch_valid),
        .o_mem_ren      (o_mem_ren),
        .o_in_resol     (in_resol),
        .o_hold         (hold)
    );

    fetch_pc u_pc (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_sent          (sent),
        .i_in_resol      (in_resol),
        .i_branch_valid  (i_branch_valid),
        .i_branch_target (i_branch_target),
        .i_branch0       (branch[0]),
        .i_compressed    (o_compressed),
        .o_pc            (o_mem_raddr)
    );

endmodule

// ==== hw/inst_pick.sv ====
`include "fetch_defs.svh"

module inst_pick (
    input  fetch_pkg::fetch_word_t i_word,
    output fetch_pkg::inst_t       o_inst0,
    output fetch_pkg::inst_t       o_inst1,
    output fetch_pkg::slot_flags_t o_compressed
);
    import fetch_pkg::*;

    // half a slot, the granule of compressed instructions
    localparam int HALF_W = `INST_W / 2;

    inst_t       slot0;
    inst_t       slot1;
    slot_flags_t comp;

    // slot 0 always sits at the bottom of the word
    assign slot0 = i_word[`INST_W-1:0];

    // low two bits other than 11 mark a 16-bit instruction
    assign comp[0] = (slot0[1:0] != 2'b11);

    // slot 1 follows right after slot 0
    // compressed slot 0 leaves it at bit 16, otherwise at bit 32
    always_comb begin
        if (comp[0]) begin
            slot1 = i_word[HALF_W +: `INST_W];
        end else begin
            slot1 = i_word[`INST_W +: `INST_W];
        end
    end

    // slot 1 length from its own opcode bits
    assign comp[1] = (slot1[1:0] != 2'b11);

    // upper half of a compressed slot is the next instruction, decode ignores it
    assign o_inst0      = slot0;
    assign o_inst1      = slot1;
    assign o_compressed = comp;

endmodule

// ==== include/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// sv39 instruction virtual address
`define FETCH_VADDR_W 39

// one read from instruction memory
`define FETCH_WORD_W 64

// one instruction slot, wide enough for an uncompressed instruction
`define INST_W 32

// first fetch after reset, bottom of the upper half of sv39 space
`define FETCH_RESET_ADDR 39'h40_0000_0000

// major opcodes of the 32-bit control-flow instructions
`define OP_JAL 7'b1101111
`define OP_JALR 7'b1100111
`define OP_BRANCH 7'b1100011

// compressed quadrants holding jumps and branches
`define C_Q1 2'b01
`define C_Q2 2'b10

`endif

// ==== sim/tb_clk_gen.sv ====
module tb_clk_gen (
    output logic o_clk,
    output logic o_rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    // 4 ns period
    localparam real HALF_PERIOD  = 2.0;
    localparam int  RESET_CYCLES = 3;

    initial begin
        o_clk = 1'b0;
        forever begin
            #(HALF_PERIOD);
            o_clk = ~o_clk;
        end
    end

    // release on a rising edge, like any other driven input
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

// ==== sim/tb_fetch_unit.sv ====
`include "fetch_defs.svh"

module tb_fetch_unit;
    timeunit 1ns;
    timeprecision 100ps;

    import fetch_pkg::*;

    localparam int NUM_ROWS    = 14;
    // a row needs at most 3 latency, 3 stall and 2 branch cycles
    localparam int CYCLE_LIMIT = NUM_ROWS * 20 + 50;

    logic        clk;
    logic        rst_n;
    logic        mem_ren;
    vaddr_t      mem_raddr;
    fetch_word_t mem_rdata;
    logic        mem_valid;
    vaddr_t      branch_target;
    logic        branch_valid;
    logic        output_ready;
    logic        output_valid;
    inst_t       inst0;
    inst_t       inst1;
    slot_flags_t compressed;
    logic        count;

    // stimulus table, the stall column comes from the lfsr
    fetch_word_t row_word [NUM_ROWS];
    int          row_delay [NUM_ROWS];
    int          row_stall [NUM_ROWS];
    vaddr_t      row_target [NUM_ROWS];
    int          row_fill = 0;

    // reference model for the row in flight
    inst_t       exp_inst0;
    inst_t       exp_inst1;
    slot_flags_t exp_comp;
    logic        exp_count;
    logic        exp_branched;
    int          exp_step;
    vaddr_t      exp_addr;

    logic [7:0]  lfsr;
    int          cycle_count = 0;

    tb_clk_gen u_clk_gen (
        .o_clk   (clk),
        .o_rst_n (rst_n)
    );

    fetch_unit u_fetch_unit (
        .i_clk           (clk),
        .i_rst_n         (rst_n),
        .o_mem_ren       (mem_ren),
        .o_mem_raddr     (mem_raddr),
        .i_mem_rdata     (mem_rdata),
        .i_mem_valid     (mem_valid),
        .i_branch_target (branch_target),
        .i_branch_valid  (branch_valid),
        .i_output_ready  (output_ready),
        .o_output_valid  (output_valid),
        .o_inst0         (inst0),
        .o_inst1         (inst1),
        .o_compressed    (compressed),
        .o_count         (count)
    );

    task automatic check_vaddr(input string name, input vaddr_t got, input vaddr_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_inst(input string name, input inst_t got, input inst_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_flags(input string name, input slot_flags_t got,
                               input slot_flags_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %s got %h expected %h", name, got, exp);
            $display("Errors found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // x^8 + x^6 + x^5 + x^4 + 1, new bit enters at the lsb
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        logic feedback;
        feedback = state[7] ^ state[5] ^ state[4] ^ state[3];
        return {state[6:0], feedback};
    endfunction

    // control flow as the isa defines it, rv64 so no c.jal
    function automatic logic is_ctrl_flow(input inst_t inst, input logic comp);
        logic [2:0] f3;
        f3 = inst[15:13];
        if (!comp) begin
            return inst[6:0] inside {`OP_JAL, `OP_JALR, `OP_BRANCH};
        end
        if (inst[1:0] == `C_Q1) begin
            return f3 inside {3'b101, 3'b110, 3'b111};
        end
        return (inst[1:0] == `C_Q2) && (f3 == 3'b100) && (inst[6:2] == 5'd0) &&
               (inst[11:7] != 5'd0);
    endfunction

    // slots, flags, count and pc step for one fetch word
    task automatic model_row(input fetch_word_t word);
        logic br0;
        logic br1;
        exp_inst0   = word[31:0];
        exp_comp[0] = (exp_inst0[1:0] != 2'b11);
        exp_inst1   = exp_comp[0] ? word[47:16] : word[63:32];
        exp_comp[1] = (exp_inst1[1:0] != 2'b11);
        br0 = is_ctrl_flow(exp_inst0, exp_comp[0]);
        br1 = is_ctrl_flow(exp_inst1, exp_comp[1]);
        exp_count    = !br0;
        exp_branched = br0 || br1;
        if (br0) begin
            exp_step = exp_comp[0] ? 2 : 4;
        end else begin
            exp_step = 8 - 2 * (int'(exp_comp[0]) + int'(exp_comp[1]));
        end
    endtask

    task automatic add_row(input fetch_word_t word, input int delay, input vaddr_t target);
        row_word[row_fill]   = word;
        row_delay[row_fill]  = delay;
        row_target[row_fill] = target;
        row_fill++;
    endtask

    // every input returns to idle unless the caller drives it again this edge
    task automatic next_cycle();
        @(posedge clk);
        mem_valid    <= 1'b0;
        branch_valid <= 1'b0;
        output_ready <= 1'b0;
    endtask

    task automatic wait_request();
        while (mem_ren !== 1'b1) begin
            next_cycle();
            @(negedge clk);
        end
    endtask

    task automatic verify_output(input logic exp_ren);
        check_bit("o_output_valid", output_valid, 1'b1);
        check_inst("o_inst0", inst0, exp_inst0);
        check_inst("o_inst1", inst1, exp_inst1);
        check_flags("o_compressed", compressed, exp_comp);
        check_bit("o_count", count, exp_count);
        check_bit("o_mem_ren", mem_ren, exp_ren);
    endtask

    // one quiet cycle in RESOL, then the resolved target
    // the port already shows the pc stepped past the sent word
    task automatic resolve_branch(input vaddr_t target);
        next_cycle();
        @(negedge clk);
        check_bit("o_mem_ren", mem_ren, 1'b0);
        check_bit("o_output_valid", output_valid, 1'b0);
        check_vaddr("o_mem_raddr", mem_raddr, exp_addr);
        next_cycle();
        branch_valid  <= 1'b1;
        branch_target <= target;
        @(negedge clk);
        check_bit("o_mem_ren", mem_ren, 1'b1);
        exp_addr = target;
    endtask

    task automatic run_row(input int r);
        int k;
        int s;
        model_row(row_word[r]);
        wait_request();
        // address shows on the port from the cycle after the request
        for (k = 1; k <= row_delay[r]; k++) begin
            next_cycle();
            if (k == row_delay[r]) begin
                mem_valid    <= 1'b1;
                mem_rdata    <= row_word[r];
                output_ready <= (row_stall[r] == 0);
            end
            @(negedge clk);
            if (k == 1) begin
                check_vaddr("o_mem_raddr", mem_raddr, exp_addr);
            end
            if (k < row_delay[r]) begin
                check_bit("o_output_valid", output_valid, 1'b0);
                check_bit("o_mem_ren", mem_ren, 1'b0);
            end
        end
        verify_output(row_stall[r] == 0 && !exp_branched);
        // decode stall, held copy must not move and no read may start
        for (s = 1; s <= row_stall[r]; s++) begin
            next_cycle();
            output_ready <= (s == row_stall[r]);
            @(negedge clk);
            verify_output(s == row_stall[r] && !exp_branched);
        end
        // pc steps on every send, a branch then replaces it with the target
        exp_addr = exp_addr + vaddr_t'(exp_step);
        if (exp_branched) begin
            resolve_branch(row_target[r]);
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout, fetch unit stopped making progress after %0d cycles",
                     cycle_count);
            $display("Errors found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int r;
        int b;
        mem_rdata     = '0;
        mem_valid     = 1'b0;
        branch_target = '0;
        branch_valid  = 1'b0;
        output_ready  = 1'b0;

        // 32-bit pairs, mixed lengths, then every jump and branch form
        add_row(64'h0010_0093_0010_0093, 1, '0);
        add_row(64'h0001_0085_0010_0093, 2, '0);
        add_row(64'h0001_0010_0093_0085, 3, '0);
        // c.addiw lives where rv32 has c.jal
        add_row(64'h0001_0001_2085_0085, 1, '0);
        add_row(64'h0010_0093_0080_006f, 2, 39'h40_0000_0100);
        add_row(64'h0000_8067_0010_0093, 3, 39'h40_0000_0204);
        add_row(64'h0010_0093_0000_0463, 1, 39'h40_0000_0302);
        // c.j, c.beqz in slot 1, c.bnez, c.jr
        add_row(64'h0001_0001_0085_a001, 3, 39'h40_0000_0400);
        add_row(64'h0001_0001_c001_0085, 2, 39'h40_0000_0506);
        add_row(64'h0001_0001_0085_e001, 1, 39'h40_0000_0600);
        add_row(64'h0001_0001_0085_8082, 2, 39'h7f_ffff_fff0);
        // c.jalr behind a 32-bit slot 0
        add_row(64'h0001_9082_0010_0093, 3, 39'h40_0000_0800);
        // c.ebreak and c.mv share funct3 with c.jr but do not jump
        add_row(64'h0001_0001_808a_9002, 1, '0);
        add_row(64'h0080_006f_0010_0093, 2, 39'h40_0000_0a00);

        // two lfsr bits per row, stall of 0 to 3 cycles
        lfsr = 8'd89;
        for (r = 0; r < NUM_ROWS; r++) begin
            row_stall[r] = 0;
            for (b = 0; b < 2; b++) begin
                lfsr = lfsr_next(lfsr);
                row_stall[r] = row_stall[r] | (int'(lfsr[0]) << b);
            end
        end
        exp_addr = `FETCH_RESET_ADDR;

        // quiet during reset
        @(negedge clk);
        while (!rst_n) begin
            check_bit("o_mem_ren", mem_ren, 1'b0);
            check_bit("o_output_valid", output_valid, 1'b0);
            @(negedge clk);
        end
        // INIT cycle has nothing to present yet
        check_bit("o_output_valid", output_valid, 1'b0);

        for (r = 0; r < NUM_ROWS; r++) begin
            run_row(r);
        end
        $display("No errors");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
hw/fetch_pkg.sv
hw/inst_pick.sv
hw/branch_predecode.sv
hw/fetch_ctrl.sv
hw/fetch_pc.sv
hw/fetch_hold.sv
hw/fetch_unit.sv
sim/tb_clk_gen.sv
sim/tb_fetch_unit.sv
